// File: Makefile
TOP := tb_tsc_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: files.f
src/tsc_pkg.sv
src/control_fsm.sv
src/inst_decode.sv
src/alu_exec.sv
src/mem_result.sv
src/tsc_core.sv
tb/tsc_core_props.sv
tb/tb_tsc_core.sv

// File: src/alu_exec.sv
module alu_exec (
  input  logic                       clk,
  input  logic                       rst_n,
  input  tsc_pkg::ctrl_t             ctrl,
  input  tsc_pkg::dec_t              dec,
  output logic [tsc_pkg::word_w-1:0] alu_now,
  output logic [tsc_pkg::word_w-1:0] alu_out,
  output logic                       taken
);
  import tsc_pkg::*;

  logic [word_w-1:0] op_a;
  logic [word_w-1:0] op_b;

  always_comb begin
    op_a = (ctrl.alu_a == a_rs) ? dec.rs_val : dec.pc;
    case (ctrl.alu_b)
      b_rt:    op_b = dec.rt_val;
      b_one:   op_b = 16'd1;
      b_imm:   op_b = dec.imm;
      default: op_b = '0;
    endcase
  end

  // plain add unless the instruction picks the operation
  always_comb begin
    alu_now = op_a + op_b;
    if (ctrl.alu_func) begin
      case (dec.opcode)
        ori_op: alu_now = op_a | op_b;
        lhi_op: alu_now = op_b;
        rtype_op: begin
          case (dec.func)
            func_sub: alu_now = op_a - op_b;
            func_and: alu_now = op_a & op_b;
            func_orr: alu_now = op_a | op_b;
            func_not: alu_now = ~op_a;
            func_tcp: alu_now = ~op_a + 16'd1;
            func_shl: alu_now = {op_a[14:0], 1'b0};
            // arithmetic shift
            func_shr: alu_now = {op_a[15], op_a[15:1]};
            default:  alu_now = op_a + op_b;
          endcase
        end
        default: alu_now = op_a + op_b;
      endcase
    end
  end

  always_comb begin
    case (dec.opcode)
      bne_op:  taken = dec.rs_val != dec.rt_val;
      beq_op:  taken = dec.rs_val == dec.rt_val;
      bgz_op:  taken = !dec.rs_val[15] && (dec.rs_val != '0);
      blz_op:  taken = dec.rs_val[15];
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_out <= '0;
    end else begin
      alu_out <= alu_now;
    end
  end

endmodule

// File: src/control_fsm.sv
module control_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  tsc_pkg::opcode_e opcode,
  input  tsc_pkg::func_e   func,
  input  logic             bus_ack,
  output tsc_pkg::ctrl_t   ctrl
);
  import tsc_pkg::*;

  state_e state, state_nxt;
  // keeps the first fetch off the bus until reset is released
  logic   started;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= s_if;
      started <= 1'b0;
    end else begin
      state   <= state_nxt;
      started <= 1'b1;
    end
  end

  always_comb begin
    state_nxt = s_if;
    case (state)
      s_if:     state_nxt = bus_ack ? s_id : s_if;
      s_id: begin
        case (opcode)
          rtype_op: begin
            case (func)
              func_jpr: state_nxt = s_jpr;
              func_jrl: state_nxt = s_jrl;
              func_wwd: state_nxt = s_wwd;
              func_hlt: state_nxt = s_hlt;
              default:  state_nxt = s_r_ex;
            endcase
          end
          adi_op, ori_op, lhi_op:         state_nxt = s_i_ex;
          lwd_op, swd_op:                 state_nxt = s_mem_ex;
          bne_op, beq_op, bgz_op, blz_op: state_nxt = s_b_check;
          jal_op:                         state_nxt = s_jal;
          jmp_op:                         state_nxt = s_jmp;
          // illegal opcode stops the core
          default:                        state_nxt = s_hlt;
        endcase
      end
      s_r_ex:    state_nxt = s_r_wb;
      s_i_ex:    state_nxt = s_i_wb;
      s_mem_ex:  state_nxt = (opcode == lwd_op) ? s_ld_mem : s_sd_mem;
      s_ld_mem:  state_nxt = bus_ack ? s_ld_wb : s_ld_mem;
      s_sd_mem:  state_nxt = bus_ack ? s_if : s_sd_mem;
      s_b_check: state_nxt = s_b_done;
      s_hlt:     state_nxt = s_hlt;
      default:   state_nxt = s_if;
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (state)
      s_if: begin
        // pc + 1 goes back to pc when the fetch completes
        ctrl.mem_read = started;
        ctrl.ir_write = started & bus_ack;
        ctrl.pc_write = started & bus_ack;
        ctrl.alu_b    = b_one;
      end
      s_id: begin
        ctrl.alu_b = b_imm;
      end
      s_r_ex: begin
        ctrl.alu_a    = a_rs;
        ctrl.alu_func = 1'b1;
      end
      s_r_wb: begin
        ctrl.dest     = dest_rd;
        ctrl.new_inst = 1'b1;
      end
      s_i_ex: begin
        ctrl.alu_a    = a_rs;
        ctrl.alu_b    = b_imm;
        ctrl.alu_func = 1'b1;
      end
      s_i_wb: begin
        ctrl.dest     = dest_rt;
        ctrl.new_inst = 1'b1;
      end
      s_mem_ex: begin
        ctrl.alu_a = a_rs;
        ctrl.alu_b = b_imm;
      end
      s_ld_mem: begin
        // address operands held so alu_out stays put during wait states
        ctrl.alu_a    = a_rs;
        ctrl.alu_b    = b_imm;
        ctrl.mem_read = 1'b1;
        ctrl.i_or_d   = 1'b1;
      end
      s_ld_wb: begin
        ctrl.dest       = dest_rt;
        ctrl.mem_to_reg = 1'b1;
        ctrl.new_inst   = 1'b1;
      end
      s_sd_mem: begin
        ctrl.alu_a     = a_rs;
        ctrl.alu_b     = b_imm;
        ctrl.mem_write = 1'b1;
        ctrl.i_or_d    = 1'b1;
        ctrl.new_inst  = 1'b1;
      end
      s_b_check: begin
        ctrl.alu_b = b_imm;
      end
      s_b_done: begin
        ctrl.alu_b         = b_imm;
        ctrl.pc_write_cond = 1'b1;
        ctrl.new_inst      = 1'b1;
      end
      s_jal: begin
        ctrl.pc_to_reg = 1'b1;
        ctrl.dest      = dest_r2;
        ctrl.pc_write  = 1'b1;
        ctrl.pc_src    = 1'b1;
        ctrl.new_inst  = 1'b1;
      end
      s_jmp: begin
        ctrl.pc_write = 1'b1;
        ctrl.pc_src   = 1'b1;
        ctrl.new_inst = 1'b1;
      end
      s_jrl: begin
        ctrl.pc_to_reg = 1'b1;
        ctrl.dest      = dest_r2;
        ctrl.alu_a     = a_rs;
        ctrl.alu_b     = b_zero;
        ctrl.pc_write  = 1'b1;
        ctrl.new_inst  = 1'b1;
      end
      s_jpr: begin
        ctrl.alu_a    = a_rs;
        ctrl.alu_b    = b_zero;
        ctrl.pc_write = 1'b1;
        ctrl.new_inst = 1'b1;
      end
      s_wwd: begin
        ctrl.wwd      = 1'b1;
        ctrl.new_inst = 1'b1;
      end
      default: begin
        ctrl.halt = 1'b1;
      end
    endcase
  end

endmodule

// File: src/inst_decode.sv
module inst_decode (
  input  logic                              clk,
  input  logic                              rst_n,
  input  tsc_pkg::ctrl_t                    ctrl,
  input  logic [tsc_pkg::word_w-1:0]        ir_data,
  input  logic                              reg_wr_en,
  input  logic [tsc_pkg::reg_idx_w-1:0]     reg_wr_idx,
  input  logic [tsc_pkg::word_w-1:0]        reg_wr_data,
  input  logic                              pc_wr_en,
  input  logic [tsc_pkg::word_w-1:0]        pc_wr_data,
  output tsc_pkg::dec_t                     dec
);
  import tsc_pkg::*;

  logic [word_w-1:0] ir;
  logic [word_w-1:0] pc;
  logic [word_w-1:0] regs [4];
  opcode_e           opcode;
  logic [word_w-1:0] imm;

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      ir <= ir_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (pc_wr_en) begin
      pc <= pc_wr_data;
    end
  end

  // r0 is writable like the others
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr_en) begin
      regs[reg_wr_idx] <= reg_wr_data;
    end
  end

  assign opcode = opcode_e'(ir[15:12]);

  always_comb begin
    case (opcode)
      ori_op:  imm = {8'h00, ir[7:0]};
      lhi_op:  imm = {ir[7:0], 8'h00};
      default: imm = {{8{ir[7]}}, ir[7:0]};
    endcase
  end

  always_comb begin
    dec.opcode = opcode;
    dec.func   = func_e'(ir[5:0]);
    dec.rs     = ir[11:10];
    dec.rt     = ir[9:8];
    dec.rd     = ir[7:6];
    dec.rs_val = regs[ir[11:10]];
    dec.rt_val = regs[ir[9:8]];
    dec.imm    = imm;
    dec.target = ir[11:0];
    dec.pc     = pc;
  end

endmodule

// File: src/mem_result.sv
module mem_result (
  input  logic                          clk,
  input  logic                          rst_n,
  input  tsc_pkg::ctrl_t                ctrl,
  input  tsc_pkg::dec_t                 dec,
  input  logic [tsc_pkg::word_w-1:0]    alu_now,
  input  logic [tsc_pkg::word_w-1:0]    alu_out,
  input  logic                          taken,
  output tsc_pkg::wb_req_t              wb_req,
  input  tsc_pkg::wb_rsp_t              wb_rsp,
  output logic                          reg_wr_en,
  output logic [tsc_pkg::reg_idx_w-1:0] reg_wr_idx,
  output logic [tsc_pkg::word_w-1:0]    reg_wr_data,
  output logic                          pc_wr_en,
  output logic [tsc_pkg::word_w-1:0]    pc_wr_data,
  output logic [tsc_pkg::word_w-1:0]    ir_data,
  output logic [tsc_pkg::word_w-1:0]    output_port,
  output logic                          output_valid,
  output logic                          halted
);
  import tsc_pkg::*;

  logic [word_w-1:0] mdr;
  logic              halt_q;

  // single classic cycle, held until ack
  always_comb begin
    wb_req.cyc   = ctrl.mem_read | ctrl.mem_write;
    wb_req.stb   = ctrl.mem_read | ctrl.mem_write;
    wb_req.we    = ctrl.mem_write;
    wb_req.adr   = ctrl.i_or_d ? alu_out : dec.pc;
    wb_req.dat_w = dec.rt_val;
  end

  assign ir_data = wb_rsp.dat_r;

  always_ff @(posedge clk) begin
    if (ctrl.mem_read && ctrl.i_or_d && wb_rsp.ack) begin
      mdr <= wb_rsp.dat_r;
    end
  end

  always_comb begin
    reg_wr_en = ctrl.dest != dest_none;
    case (ctrl.dest)
      dest_rd: reg_wr_idx = dec.rd;
      dest_rt: reg_wr_idx = dec.rt;
      default: reg_wr_idx = 2'd2;
    endcase
    // link value is the already incremented pc
    if (ctrl.pc_to_reg) begin
      reg_wr_data = dec.pc;
    end else if (ctrl.mem_to_reg) begin
      reg_wr_data = mdr;
    end else begin
      reg_wr_data = alu_out;
    end
  end

  assign pc_wr_en   = ctrl.pc_write | (ctrl.pc_write_cond & taken);
  assign pc_wr_data = ctrl.pc_src ? {dec.pc[15:12], dec.target} : alu_now;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      output_port  <= '0;
      output_valid <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      output_valid <= ctrl.wwd;
      if (ctrl.wwd) begin
        output_port <= dec.rs_val;
      end
      if (ctrl.halt) begin
        halt_q <= 1'b1;
      end
    end
  end

  // visible from the first cycle of the halt state
  assign halted = halt_q | ctrl.halt;

endmodule

// File: src/tsc_core.sv
module tsc_core (
  input  logic                       clk,
  input  logic                       rst_n,
  output tsc_pkg::wb_req_t           wb_req,
  input  tsc_pkg::wb_rsp_t           wb_rsp,
  output logic [tsc_pkg::word_w-1:0] output_port,
  output logic                       output_valid,
  output logic                       halted
);
  import tsc_pkg::*;

  ctrl_t                ctrl;
  dec_t                 dec;
  logic [word_w-1:0]    alu_now;
  logic [word_w-1:0]    alu_out;
  logic                 taken;
  logic                 reg_wr_en;
  logic [reg_idx_w-1:0] reg_wr_idx;
  logic [word_w-1:0]    reg_wr_data;
  logic                 pc_wr_en;
  logic [word_w-1:0]    pc_wr_data;
  logic [word_w-1:0]    ir_data;

  control_fsm u_control_fsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .opcode  (dec.opcode),
    .func    (dec.func),
    .bus_ack (wb_rsp.ack),
    .ctrl    (ctrl)
  );

  inst_decode u_inst_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .ir_data     (ir_data),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_idx  (reg_wr_idx),
    .reg_wr_data (reg_wr_data),
    .pc_wr_en    (pc_wr_en),
    .pc_wr_data  (pc_wr_data),
    .dec         (dec)
  );

  alu_exec u_alu_exec (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .dec     (dec),
    .alu_now (alu_now),
    .alu_out (alu_out),
    .taken   (taken)
  );

  mem_result u_mem_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl         (ctrl),
    .dec          (dec),
    .alu_now      (alu_now),
    .alu_out      (alu_out),
    .taken        (taken),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .reg_wr_en    (reg_wr_en),
    .reg_wr_idx   (reg_wr_idx),
    .reg_wr_data  (reg_wr_data),
    .pc_wr_en     (pc_wr_en),
    .pc_wr_data   (pc_wr_data),
    .ir_data      (ir_data),
    .output_port  (output_port),
    .output_valid (output_valid),
    .halted       (halted)
  );

endmodule

// File: src/tsc_pkg.sv
package tsc_pkg;

  localparam int word_w    = 16;
  localparam int addr_w    = 16;
  localparam int reg_idx_w = 2;

  typedef enum logic [3:0] {
    bne_op   = 4'd0,
    beq_op   = 4'd1,
    bgz_op   = 4'd2,
    blz_op   = 4'd3,
    adi_op   = 4'd4,
    ori_op   = 4'd5,
    lhi_op   = 4'd6,
    lwd_op   = 4'd7,
    swd_op   = 4'd8,
    jmp_op   = 4'd9,
    jal_op   = 4'd10,
    rtype_op = 4'd15
  } opcode_e;

  // r-type function field
  typedef enum logic [5:0] {
    func_add = 6'd0,
    func_sub = 6'd1,
    func_and = 6'd2,
    func_orr = 6'd3,
    func_not = 6'd4,
    func_tcp = 6'd5,
    func_shl = 6'd6,
    func_shr = 6'd7,
    func_jpr = 6'd25,
    func_jrl = 6'd26,
    func_wwd = 6'd28,
    func_hlt = 6'd29
  } func_e;

  typedef enum logic [4:0] {
    s_if, s_id, s_r_ex, s_r_wb, s_i_ex, s_i_wb, s_mem_ex, s_ld_mem, s_ld_wb,
    s_sd_mem, s_b_check, s_b_done, s_jal, s_jmp, s_jrl, s_jpr, s_wwd, s_hlt
  } state_e;

  typedef enum logic [1:0] {a_pc, a_rs} alu_a_e;
  typedef enum logic [1:0] {b_rt, b_one, b_imm, b_zero} alu_b_e;
  // r2 is the link register
  typedef enum logic [1:0] {dest_none, dest_rd, dest_rt, dest_r2} dest_e;

  typedef struct packed {
    logic   pc_write;
    logic   pc_write_cond;
    logic   i_or_d;
    logic   mem_read;
    logic   mem_write;
    logic   ir_write;
    logic   mem_to_reg;
    logic   pc_to_reg;
    logic   pc_src;
    logic   wwd;
    logic   halt;
    logic   new_inst;
    dest_e  dest;
    alu_a_e alu_a;
    alu_b_e alu_b;
    logic   alu_func;
  } ctrl_t;

  typedef struct packed {
    opcode_e                opcode;
    func_e                  func;
    logic [reg_idx_w-1:0]   rs;
    logic [reg_idx_w-1:0]   rt;
    logic [reg_idx_w-1:0]   rd;
    logic [word_w-1:0]      rs_val;
    logic [word_w-1:0]      rt_val;
    logic [word_w-1:0]      imm;
    logic [11:0]            target;
    logic [word_w-1:0]      pc;
  } dec_t;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [addr_w-1:0] adr;
    logic [word_w-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [word_w-1:0] dat_r;
  } wb_rsp_t;

endpackage

// File: tb/tb_tsc_core.sv
module tb_tsc_core;
  timeunit 1ns;
  timeprecision 100ps;
  import tsc_pkg::*;

  localparam logic [1:0] r0 = 2'd0;
  localparam logic [1:0] r1 = 2'd1;
  localparam logic [1:0] r2 = 2'd2;
  localparam logic [1:0] r3 = 2'd3;
  localparam int halt_limit = 5000;

  logic              clk = 1'b0;
  logic              rst_n;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp = '0;
  logic [word_w-1:0] output_port;
  logic              output_valid;
  logic              halted;

  logic [word_w-1:0] mem [256];
  logic [31:0]       lfsr = 32'hcd0a21b0;
  logic              pending = 1'b0;
  logic [1:0]        wait_cnt = 2'd0;
  int                tb_errors = 0;
  int                cycles;

  tsc_core UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .output_port  (output_port),
    .output_valid (output_valid),
    .halted       (halted)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] rtype_word(logic [1:0] rs, logic [1:0] rt,
                                             logic [1:0] rd, func_e func);
    return {rtype_op, rs, rt, rd, func};
  endfunction

  function automatic logic [15:0] imm_word(opcode_e op, logic [1:0] rs,
                                           logic [1:0] rt, logic [7:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [15:0] jump_word(opcode_e op, logic [11:0] target);
    return {op, target};
  endfunction

  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      mem[i[7:0]] = {i[7:0], ~i[7:0]};
    end
    // r0 = 1234 and r1 = 0ff0
    mem[8'd0]  = imm_word(lhi_op, r0, r0, 8'h12);
    mem[8'd1]  = imm_word(ori_op, r0, r0, 8'h34);
    mem[8'd2]  = imm_word(lhi_op, r0, r1, 8'h0f);
    mem[8'd3]  = imm_word(ori_op, r1, r1, 8'hf0);
    mem[8'd4]  = rtype_word(r0, r1, r2, func_add);
    mem[8'd5]  = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd6]  = rtype_word(r0, r1, r2, func_sub);
    mem[8'd7]  = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd8]  = rtype_word(r0, r1, r2, func_and);
    mem[8'd9]  = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd10] = rtype_word(r0, r1, r2, func_orr);
    mem[8'd11] = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd12] = rtype_word(r0, r0, r2, func_not);
    mem[8'd13] = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd14] = rtype_word(r0, r0, r2, func_tcp);
    mem[8'd15] = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd16] = rtype_word(r0, r0, r2, func_shl);
    mem[8'd17] = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd18] = rtype_word(r0, r0, r2, func_shr);
    mem[8'd19] = rtype_word(r2, r0, r0, func_wwd);
    // sign versus zero extension
    mem[8'd20] = imm_word(adi_op, r0, r3, 8'hfd);
    mem[8'd21] = rtype_word(r3, r0, r0, func_wwd);
    mem[8'd22] = imm_word(ori_op, r0, r3, 8'h80);
    mem[8'd23] = rtype_word(r3, r0, r0, func_wwd);
    mem[8'd24] = imm_word(lhi_op, r0, r3, 8'h00);
    mem[8'd25] = imm_word(ori_op, r3, r3, 8'h80);
    mem[8'd26] = imm_word(swd_op, r3, r0, 8'h01);
    mem[8'd27] = imm_word(lwd_op, r3, r1, 8'h01);
    mem[8'd28] = rtype_word(r1, r0, r0, func_wwd);
    // each skipped slot holds a marker that must never show up
    mem[8'd29] = imm_word(bne_op, r0, r1, 8'h01);
    mem[8'd30] = rtype_word(r3, r0, r0, func_wwd);
    mem[8'd31] = imm_word(beq_op, r0, r1, 8'h01);
    mem[8'd32] = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd33] = imm_word(beq_op, r0, r3, 8'h01);
    mem[8'd34] = rtype_word(r0, r0, r0, func_wwd);
    mem[8'd35] = imm_word(bne_op, r0, r3, 8'h01);
    mem[8'd36] = rtype_word(r3, r0, r0, func_wwd);
    mem[8'd37] = imm_word(bgz_op, r0, r0, 8'h01);
    mem[8'd38] = rtype_word(r1, r0, r0, func_wwd);
    mem[8'd39] = rtype_word(r0, r0, r1, func_tcp);
    mem[8'd40] = imm_word(bgz_op, r1, r0, 8'h01);
    mem[8'd41] = rtype_word(r1, r0, r0, func_wwd);
    mem[8'd42] = imm_word(blz_op, r1, r0, 8'h01);
    mem[8'd43] = rtype_word(r0, r0, r0, func_wwd);
    mem[8'd44] = imm_word(blz_op, r0, r0, 8'h01);
    mem[8'd45] = rtype_word(r3, r0, r0, func_wwd);
    // countdown loop with a backward branch
    mem[8'd46] = imm_word(lhi_op, r0, r3, 8'h00);
    mem[8'd47] = imm_word(ori_op, r3, r3, 8'h02);
    mem[8'd48] = rtype_word(r3, r0, r0, func_wwd);
    mem[8'd49] = imm_word(adi_op, r3, r3, 8'hff);
    mem[8'd50] = imm_word(bgz_op, r3, r0, 8'hfd);
    mem[8'd51] = jump_word(jmp_op, 12'd54);
    mem[8'd52] = rtype_word(r0, r0, r0, func_wwd);
    mem[8'd53] = rtype_word(r1, r0, r0, func_wwd);
    mem[8'd54] = jump_word(jal_op, 12'd60);
    mem[8'd55] = imm_word(ori_op, r3, r3, 8'h3e);
    mem[8'd56] = rtype_word(r3, r0, r0, func_jrl);
    mem[8'd57] = rtype_word(r3, r0, r0, func_wwd);
    mem[8'd58] = rtype_word(r0, r0, r0, func_hlt);
    mem[8'd59] = rtype_word(r0, r0, r0, func_wwd);
    // two small subroutines returning through r2
    mem[8'd60] = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd61] = rtype_word(r2, r0, r0, func_jpr);
    mem[8'd62] = rtype_word(r2, r0, r0, func_wwd);
    mem[8'd63] = rtype_word(r2, r0, r0, func_jpr);
  endtask

  task finish_transfer();
    wb_rsp.ack <= 1'b1;
    pending    <= 1'b0;
    if (wb_req.we) begin
      mem[wb_req.adr[7:0]] = wb_req.dat_w;
    end else begin
      wb_rsp.dat_r <= mem[wb_req.adr[7:0]];
    end
  endtask

  // wishbone slave with 0 to 3 wait cycles per transfer
  always @(posedge clk) begin
    logic [31:0] s;
    logic [1:0]  delay;
    if (!rst_n) begin
      wb_rsp   <= '0;
      pending  <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack <= 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!pending) begin
        s = lfsr_next(lfsr);
        delay[1] = s[0];
        s = lfsr_next(s);
        delay[0] = s[0];
        lfsr <= s;
        if (delay == 2'd0) begin
          finish_transfer();
        end else begin
          pending  <= 1'b1;
          wait_cnt <= delay - 2'd1;
        end
      end else if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else begin
        finish_transfer();
      end
    end
  end

  initial begin
    rst_n <= 1'b0;
    load_program();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    cycles = 0;
    while (!halted && cycles < halt_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timeout: core did not halt within %0d cycles", halt_limit);
      tb_errors++;
    end
    // keep the halt checks running for a while
    repeat (20) @(posedge clk);
    $display("closing: %0d testbench errors, %0d assertion failures",
             tb_errors, UUT.u_props.fail_cnt);
    if (tb_errors == 0 && UUT.u_props.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb/tsc_core_props.sv
module tsc_core_props (
  input logic                       clk,
  input logic                       rst_n,
  input tsc_pkg::wb_req_t           wb_req,
  input tsc_pkg::wb_rsp_t           wb_rsp,
  input logic [tsc_pkg::word_w-1:0] output_port,
  input logic                       output_valid,
  input logic                       halted
);
  timeunit 1ns;
  timeprecision 100ps;
  import tsc_pkg::*;

  localparam int exp_len = 20;
  // words the program writes with WWD, in order
  localparam logic [word_w-1:0] exp_wwd [exp_len] = '{
    16'h2224, 16'h0244, 16'h0230, 16'h1ff4, 16'hedcb,
    16'hedcc, 16'h2468, 16'h091a, 16'h1231, 16'h12b4,
    16'h1234, 16'h0080, 16'h1234, 16'hedcc, 16'h0080,
    16'h0002, 16'h0001, 16'h0037, 16'h0039, 16'h003e
  };
  localparam logic [addr_w-1:0] store_adr = 16'h0081;
  localparam logic [word_w-1:0] store_dat = 16'h1234;

  int   fail_cnt = 0;
  int   wwd_idx;
  logic store_seen;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wwd_idx    <= 0;
      store_seen <= 1'b0;
    end else begin
      if (output_valid) begin
        wwd_idx <= wwd_idx + 1;
      end
      if (wb_req.stb && wb_req.we && wb_rsp.ack) begin
        store_seen <= 1'b1;
      end
    end
  end

  cyc_stb_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb == wb_req.cyc)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("stb and cyc differ");
    end

  // request held until ack
  hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr) &&
      $stable(wb_req.we) && $stable(wb_req.dat_w))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("bus request changed or dropped while waiting for ack");
    end

  idle_after_reset_a: assert property (@(posedge clk)
    !rst_n || $rose(rst_n) |-> !wb_req.cyc)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("bus request open before the first fetch");
    end

  store_data_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb && wb_req.we |-> wb_req.dat_w == store_dat)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t wb_req.dat_w: got %h, expected %h",
             $time, $sampled(wb_req.dat_w), store_dat);
    end

  store_adr_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb && wb_req.we |-> wb_req.adr == store_adr)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t wb_req.adr: got %h, expected %h",
             $time, $sampled(wb_req.adr), store_adr);
    end

  wwd_value_a: assert property (@(posedge clk) disable iff (!rst_n)
    output_valid && wwd_idx < exp_len |-> output_port == exp_wwd[wwd_idx])
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t output_port: got %h, expected %h",
             $time, $sampled(output_port), exp_wwd[$sampled(wwd_idx)]);
    end

  wwd_extra_a: assert property (@(posedge clk) disable iff (!rst_n)
    output_valid |-> wwd_idx < exp_len)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("more output words than the program writes");
    end

  final_count_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(halted) |-> wwd_idx == exp_len)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t wwd_idx: got %0d, expected %0d",
             $time, $sampled(wwd_idx), exp_len);
    end

  store_done_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(halted) |-> store_seen)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("core halted without completing a store");
    end

  halt_sticky_a: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("halted dropped before reset");
    end

  halt_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !wb_req.cyc)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("bus request raised after halt");
    end

endmodule

bind tsc_core tsc_core_props u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .wb_req       (wb_req),
  .wb_rsp       (wb_rsp),
  .output_port  (output_port),
  .output_valid (output_valid),
  .halted       (halted)
);
